/* hw/sp_arith_pkg.sv */
`default_nettype none

package sp_arith_pkg;

    localparam int FP_BIAS = 127;
    localparam int FRAC_BITS = 23;
    localparam int EXP_BITS = 8;

    typedef logic [31:0] word_t;
    typedef logic [EXP_BITS-1:0] fp_exp_t;
    typedef logic [FRAC_BITS:0] fp_mant_t; // Hidden bit included.

    typedef struct packed {
        logic sign;
        fp_exp_t exp;
        logic [FRAC_BITS-1:0] frac;
    } fp_fields_t;

    typedef enum logic [2:0] {
        OP_DIVU,
        OP_DIVS,
        OP_ADDF,
        OP_SUBF,
        OP_MULF
    } op_t;

    typedef struct packed {
        op_t op;
        word_t a;
        word_t b;
    } req_t;

endpackage

`default_nettype wire

/* hw/sp_int_div.sv */
`timescale 1ns/1ps
`default_nettype none

module sp_int_div #(
    parameter int WIDTH = 32
) (
    input logic clk,
    input logic rst,
    input logic start,
    input logic is_signed,
    input logic [WIDTH-1:0] a,
    input logic [WIDTH-1:0] b,
    output logic [WIDTH-1:0] result,
    output logic done
);

    localparam int CNT_BITS = $clog2(WIDTH + 1);

    logic [CNT_BITS-1:0] count;
    logic [2*WIDTH-1:0] work; // Remainder on top, quotient shifting in below.
    logic [WIDTH-1:0] divisor;
    logic negate;
    logic [WIDTH-1:0] a_abs;
    logic [WIDTH-1:0] b_abs;
    logic [WIDTH+1:0] trial;
    logic [WIDTH-1:0] quot;

    assign a_abs = (is_signed && a[WIDTH-1]) ? -a : a;
    assign b_abs = (is_signed && b[WIDTH-1]) ? -b : b;

    // Full window keeps the top remainder bit for large divisors.
    assign trial = {1'b0, work[2*WIDTH-1:WIDTH-1]} - {2'b00, divisor};

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else if (start) begin
            count <= CNT_BITS'(WIDTH);
        end else if (!done) begin
            count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            work <= {{WIDTH{1'b0}}, a_abs};
            divisor <= b_abs;
            negate <= is_signed & (a[WIDTH-1] ^ b[WIDTH-1]);
        end else if (!done) begin
            if (trial[WIDTH+1]) begin
                work <= {work[2*WIDTH-2:0], 1'b0}; // Borrow, restore.
            end else begin
                work <= {trial[WIDTH-1:0], work[WIDTH-2:0], 1'b1};
            end
        end
    end

    assign quot = work[WIDTH-1:0];
    assign result = negate ? -quot : quot;
    assign done = count == '0;

endmodule

`default_nettype wire

/* hw/sp_mul_iter.sv */
`timescale 1ns/1ps
`default_nettype none

module sp_mul_iter #(
    parameter int MUL_BITS = 8 // Must divide the significand width.
) (
    input logic clk,
    input logic rst,
    input logic start,
    input sp_arith_pkg::fp_mant_t a,
    input sp_arith_pkg::fp_mant_t b,
    output logic [2*$bits(sp_arith_pkg::fp_mant_t)-1:0] product,
    output logic ready
);

    import sp_arith_pkg::*;

    localparam int MANT_BITS = FRAC_BITS + 1;
    localparam int PROD_BITS = 2 * MANT_BITS;
    localparam int STEPS = MANT_BITS / MUL_BITS;
    localparam int CNT_BITS = $clog2(STEPS + 1);

    logic [CNT_BITS-1:0] count;
    fp_mant_t a_reg;
    fp_mant_t b_reg;
    logic [PROD_BITS-1:0] acc;
    logic [PROD_BITS-1:0] partial;

    assign partial = {{(PROD_BITS-MANT_BITS){1'b0}}, b_reg}
                   * {{(PROD_BITS-MUL_BITS){1'b0}}, a_reg[MANT_BITS-1 -: MUL_BITS]};

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else if (start) begin
            count <= CNT_BITS'(STEPS);
        end else if (!ready) begin
            count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            acc <= '0;
            a_reg <= a;
            b_reg <= b;
        end else if (!ready) begin
            acc <= (acc << MUL_BITS) + partial; // Top digits of a first.
            a_reg <= a_reg << MUL_BITS;
        end
    end

    assign product = acc;
    assign ready = count == '0;

endmodule

`default_nettype wire

/* hw/sp_float_add.sv */
`timescale 1ns/1ps
`default_nettype none

module sp_float_add (
    input logic clk,
    input logic rst,
    input logic start,
    input logic negate_b,
    input sp_arith_pkg::word_t a,
    input sp_arith_pkg::word_t b,
    output sp_arith_pkg::word_t result,
    output logic done
);

    import sp_arith_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        ALIGN,
        SIGN,
        SUM,
        NORM
    } state_t;

    typedef logic signed [FRAC_BITS+2:0] acc_t; // Two guard bits for carry and sign.

    state_t state;
    fp_fields_t a_reg;
    fp_fields_t b_reg;
    fp_mant_t frac_a;
    fp_mant_t frac_b;
    fp_exp_t diff_ab;
    fp_exp_t diff_ba;
    acc_t mant_a;
    acc_t mant_b;
    acc_t sum;
    acc_t neg_sum;
    logic sum_sign;
    logic res_sign;
    fp_exp_t res_exp;
    logic [FRAC_BITS+1:0] mag;

    // Exponent zero reads as zero.
    assign frac_a = (a_reg.exp == '0) ? '0 : {1'b1, a_reg.frac};
    assign frac_b = (b_reg.exp == '0) ? '0 : {1'b1, b_reg.frac};
    assign diff_ab = a_reg.exp - b_reg.exp;
    assign diff_ba = b_reg.exp - a_reg.exp;
    assign sum = mant_a + mant_b;
    assign neg_sum = -sum;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        a_reg <= a;
                        b_reg <= {b[31] ^ negate_b, b[30:0]}; // Subtract flips b.
                        state <= ALIGN;
                    end
                end
                ALIGN: begin
                    if (a_reg.exp > b_reg.exp) begin
                        mant_a <= {2'b00, frac_a};
                        mant_b <= {2'b00, frac_b >> diff_ab};
                        res_exp <= a_reg.exp;
                    end else begin
                        mant_a <= {2'b00, frac_a >> diff_ba};
                        mant_b <= {2'b00, frac_b};
                        res_exp <= b_reg.exp;
                    end
                    state <= SIGN;
                end
                SIGN: begin
                    if (a_reg.sign != b_reg.sign) begin
                        if (a_reg.sign) begin
                            mant_a <= -mant_a;
                        end else begin
                            mant_b <= -mant_b;
                        end
                        sum_sign <= 1'b0;
                    end else begin
                        sum_sign <= a_reg.sign;
                    end
                    state <= SUM;
                end
                SUM: begin
                    if (sum[FRAC_BITS+2]) begin
                        res_sign <= 1'b1;
                        mag <= neg_sum[FRAC_BITS+1:0];
                    end else begin
                        res_sign <= sum_sign;
                        mag <= sum[FRAC_BITS+1:0];
                    end
                    state <= NORM;
                end
                NORM: begin
                    if (mag[FRAC_BITS+1]) begin
                        mag <= {1'b0, mag[FRAC_BITS+1:1]}; // Carry out.
                        res_exp <= res_exp + 1'b1;
                        state <= IDLE;
                    end else if (mag == '0) begin
                        res_sign <= 1'b0;
                        res_exp <= '0;
                        state <= IDLE;
                    end else if (!mag[FRAC_BITS]) begin
                        mag <= {mag[FRAC_BITS:0], 1'b0}; // One step per cycle.
                        res_exp <= res_exp - 1'b1;
                    end else begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    assign result = {res_sign, res_exp, mag[FRAC_BITS-1:0]};
    assign done = state == IDLE;

endmodule

`default_nettype wire

/* hw/sp_float_mul.sv */
`timescale 1ns/1ps
`default_nettype none

module sp_float_mul #(
    parameter int MUL_BITS = 8
) (
    input logic clk,
    input logic rst,
    input logic start,
    input sp_arith_pkg::word_t a,
    input sp_arith_pkg::word_t b,
    output sp_arith_pkg::word_t result,
    output logic done
);

    import sp_arith_pkg::*;

    localparam int PROD_BITS = 2 * (FRAC_BITS + 1);

    typedef enum logic [1:0] {
        IDLE,
        SMULT,
        MULT,
        NORM
    } state_t;

    state_t state;
    fp_fields_t a_reg;
    fp_fields_t b_reg;
    fp_mant_t frac_a;
    fp_mant_t frac_b;
    logic res_sign;
    fp_exp_t res_exp;
    logic [PROD_BITS-1:0] product;
    logic [PROD_BITS-1:0] mul_product;
    logic mul_ready;

    assign frac_a = (a_reg.exp == '0) ? '0 : {1'b1, a_reg.frac};
    assign frac_b = (b_reg.exp == '0) ? '0 : {1'b1, b_reg.frac};

    sp_mul_iter #(
        .MUL_BITS(MUL_BITS)
    ) u_mul (
        .clk(clk),
        .rst(rst),
        .start(state == SMULT),
        .a(frac_a),
        .b(frac_b),
        .product(mul_product),
        .ready(mul_ready)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        a_reg <= a;
                        b_reg <= b;
                        state <= SMULT;
                    end
                end
                SMULT: begin
                    res_sign <= a_reg.sign ^ b_reg.sign;
                    res_exp <= a_reg.exp + b_reg.exp;
                    state <= MULT;
                end
                MULT: begin
                    if (mul_ready) begin
                        product <= mul_product;
                        // Product lies in [1,4), so one is added back here.
                        res_exp <= res_exp - fp_exp_t'(FP_BIAS - 1);
                        state <= NORM;
                    end
                end
                NORM: begin
                    if (product == '0) begin
                        res_sign <= 1'b0;
                        res_exp <= '0;
                    end else if (!product[PROD_BITS-1]) begin
                        product <= {product[PROD_BITS-2:0], 1'b0};
                        res_exp <= res_exp - 1'b1;
                    end
                    state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    assign result = {res_sign, res_exp, product[PROD_BITS-2 -: FRAC_BITS]};
    assign done = state == IDLE;

endmodule

`default_nettype wire

/* hw/sp_arith_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module sp_arith_unit #(
    parameter int DIV_WIDTH = 32,
    parameter int MUL_BITS = 8
) (
    input logic clk,
    input logic rst,
    input logic start,
    input sp_arith_pkg::req_t req,
    output sp_arith_pkg::word_t result,
    output logic ready
);

    import sp_arith_pkg::*;

    op_t busy_op;
    logic busy;
    logic accept;
    logic div_done;
    logic add_done;
    logic mul_done;
    logic [DIV_WIDTH-1:0] div_result;
    word_t add_result;
    word_t mul_result;
    logic sel_done;
    word_t sel_result;

    assign accept = start & ready; // Starts while busy are dropped.
    assign ready = !busy;

    sp_int_div #(
        .WIDTH(DIV_WIDTH)
    ) u_div (
        .clk(clk),
        .rst(rst),
        .start(accept && (req.op == OP_DIVU || req.op == OP_DIVS)),
        .is_signed(req.op == OP_DIVS),
        .a(req.a),
        .b(req.b),
        .result(div_result),
        .done(div_done)
    );

    sp_float_add u_add (
        .clk(clk),
        .rst(rst),
        .start(accept && (req.op == OP_ADDF || req.op == OP_SUBF)),
        .negate_b(req.op == OP_SUBF),
        .a(req.a),
        .b(req.b),
        .result(add_result),
        .done(add_done)
    );

    sp_float_mul #(
        .MUL_BITS(MUL_BITS)
    ) u_mul (
        .clk(clk),
        .rst(rst),
        .start(accept && req.op == OP_MULF),
        .a(req.a),
        .b(req.b),
        .result(mul_result),
        .done(mul_done)
    );

    always_comb begin
        case (busy_op)
            OP_DIVU, OP_DIVS: begin
                sel_done = div_done;
                sel_result = div_result;
            end
            OP_ADDF, OP_SUBF: begin
                sel_done = add_done;
                sel_result = add_result;
            end
            OP_MULF: begin
                sel_done = mul_done;
                sel_result = mul_result;
            end
            default: begin
                sel_done = 1'b1; // Unknown op finishes at once with zero.
                sel_result = '0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            busy_op <= OP_DIVU;
            result <= '0;
        end else if (accept) begin
            busy <= 1'b1;
            busy_op <= req.op;
        end else if (busy && sel_done) begin
            busy <= 1'b0;
            result <= sel_result;
        end
    end

endmodule

`default_nettype wire

/* tb/sp_arith_unit_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module sp_arith_unit_asserts (
    input logic clk,
    input logic rst,
    input logic start,
    input logic ready,
    input sp_arith_pkg::word_t result
);

    property p_ready_falls;
        @(posedge clk) disable iff (rst) (start && ready) |=> !ready;
    endproperty

    property p_ready_after_reset;
        @(posedge clk) rst |=> ready;
    endproperty

    // Answer is held until the next accepted start.
    property p_result_held;
        @(posedge clk) disable iff (rst) (ready && !start) |=> $stable(result);
    endproperty

    a_ready_falls: assert property (p_ready_falls)
        else $error("ready did not fall after an accepted start");

    a_ready_after_reset: assert property (p_ready_after_reset)
        else $error("ready was low in the cycle after reset");

    a_result_held: assert property (p_result_held)
        else $error("result changed while the unit was idle");

endmodule

bind sp_arith_unit sp_arith_unit_asserts u_asserts (
    .clk(clk),
    .rst(rst),
    .start(start),
    .ready(ready),
    .result(result)
);

`default_nettype wire

/* tb/sp_arith_unit_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module sp_arith_unit_tb;

    import sp_arith_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int TIMEOUT_CYCLES = 200;
    localparam int QUIET_CYCLES = 40;
    localparam string VEC_FILE = "tb/sp_arith_input.txt";

    logic clk;
    logic rst;
    logic start;
    req_t req;
    word_t result;
    logic ready;

    int errors;
    int tests;
    int failed;
    logic timed_out;

    sp_arith_unit #(
        .DIV_WIDTH(32),
        .MUL_BITS(8)
    ) DUT (
        .clk(clk),
        .rst(rst),
        .start(start),
        .req(req),
        .result(result),
        .ready(ready)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Checks that ready and result stay steady after a run that saw a stray start.
    task automatic watch_idle(input word_t expected);
        int i;
        for (i = 0; i < QUIET_CYCLES; i++) begin
            @(negedge clk);
            assert (ready)
                else begin
                    $display("test %0d: ready fell again with no accepted start", tests);
                    errors++;
                end
            assert (result === expected)
                else begin
                    $display("mismatch at %0t: test %0d result changed to %h, expected %h",
                             $time, tests, result, expected);
                    errors++;
                end
        end
    endtask

    task automatic run_vector(input logic [2:0] op_val, input word_t a, input word_t b,
                              input word_t expected, input int poke);
        int cycles;
        int errs_before;
        errs_before = errors;
        @(negedge clk);
        req.op = op_t'(op_val);
        req.a = a;
        req.b = b;
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        cycles = 0;
        while (!ready && cycles < TIMEOUT_CYCLES) begin
            if (poke != 0 && cycles == poke) begin
                req.op = OP_MULF; // Would give 4.0 if it were taken.
                req.a = 32'h4000_0000;
                req.b = 32'h4000_0000;
                start = 1'b1;
            end else begin
                start = 1'b0;
            end
            @(negedge clk);
            cycles++;
        end
        start = 1'b0;
        if (!ready) begin
            $display("timeout: ready stayed low for %0d cycles in test %0d",
                     TIMEOUT_CYCLES, tests);
            errors++;
            timed_out = 1'b1;
        end else begin
            assert (result === expected)
                else begin
                    $display("mismatch at %0t: test %0d op %0d a %h b %h, result %h, expected %h",
                             $time, tests, op_val, a, b, result, expected);
                    errors++;
                end
            if (poke != 0) begin
                watch_idle(expected);
            end
        end
        if (errors != errs_before) begin
            failed++;
        end
        $display("test %0d op %0d a %h b %h result %h after %0d cycles: %s", tests, op_val,
                 a, b, result, cycles + 1, (errors == errs_before) ? "ok" : "FAILED");
        tests++;
    endtask

    initial begin
        int fd;
        int code;
        string line;
        logic [31:0] op_val;
        word_t a_val;
        word_t b_val;
        word_t exp_val;
        logic [31:0] poke_val;
        errors = 0;
        tests = 0;
        failed = 0;
        timed_out = 1'b0;
        rst = 1'b1;
        start = 1'b0;
        req = '0;
        repeat (2) @(negedge clk);
        rst = 1'b0;
        fd = $fopen(VEC_FILE, "r");
        if (fd == 0) begin
            $display("cannot open the stimulus file %s", VEC_FILE);
            $display("Errors found");
            $finish;
        end else begin
            while (!$feof(fd) && !timed_out) begin
                code = $fgets(line, fd);
                if (code > 0 && $sscanf(line, "%h %h %h %h %h",
                                        op_val, a_val, b_val, exp_val, poke_val) == 5) begin
                    run_vector(op_val[2:0], a_val, b_val, exp_val, int'(poke_val));
                end
            end
            $fclose(fd);
            if (tests == 0) begin
                $display("no test vectors were read from %s", VEC_FILE);
                errors++;
            end
            $display("%0d tests run, %0d passed, %0d failed, %0d errors",
                     tests, tests - failed, failed, errors);
            if (errors == 0) begin
                $display("No errors");
            end else begin
                $display("Errors found");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

/* tb/sp_arith_input.txt */
# op a b expected poke, all hex; op 0 divu, 1 divs, 2 addf, 3 subf, 4 mulf
# poke is the wait cycle of a stray start sent while busy, 0 for none
0 000003e8 00000007 0000008e 0
0 ffffffff 00000001 ffffffff 0
0 00000064 00000000 ffffffff 0
0 80000000 00000003 2aaaaaaa 5
0 00000005 0000000a 00000000 0
0 ffffffff 80000000 00000001 0
1 fffffc18 00000007 ffffff72 0
1 000003e8 fffffff9 ffffff72 0
1 fffffc18 fffffff9 0000008e 20
1 fffffff9 00000002 fffffffd 0
2 3fc00000 40100000 40700000 0
2 40200000 c0200000 00000000 2
2 3f800000 3f800000 40000000 0
2 bfc00000 3f000000 bf800000 0
3 40a00000 3fa00000 40700000 0
3 3f800000 3f400000 3e800000 0
3 40000000 40400000 bf800000 0
3 3f800000 bf800000 40000000 0
4 40400000 c0200000 c0f00000 0
4 00000000 40a00000 00000000 0
4 3fc00000 3fc00000 40100000 0
4 c0800000 be800000 3f800000 0
4 80000000 40400000 00000000 3

/* sources.f */
hw/sp_arith_pkg.sv
hw/sp_int_div.sv
hw/sp_mul_iter.sv
hw/sp_float_add.sv
hw/sp_float_mul.sv
hw/sp_arith_unit.sv
tb/sp_arith_unit_asserts.sv
tb/sp_arith_unit_tb.sv

/* Makefile */
TOP := sp_arith_unit_tb
LOG := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f sources.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Errors found" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi
	@if ! grep -q "No errors" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
